//--- compile.f
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/instrPredecode.sv
hdl/instrQueue.sv
hdl/hazardIssue.sv
hdl/issueFrontEnd.sv
testbench/issueFrontEndTb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = issueFrontEndTb
FILELIST  = compile.f
BUILD     = obj_dir
PASS      = All tests passed!

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee /dev/stderr | grep -qF "$(PASS)"

clean:
	rm -rf $(BUILD)

//--- testbench/issueFrontEndTb.sv
`timescale 1ns/10ps

module issueFrontEndTb;
    import isaPkg::*;
    import pipePkg::*;

    localparam int QueueDepth = DefaultQueueDepth;
    localparam int WaitLimit  = 200;

    // issue spacing from the pipeline rules
    localparam int DepSpacing  = 5;
    localparam int CtrlSpacing = 2;
    localparam int FillLatency = 3;

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    logic  instrValid = 1'b0;
    instrT instr = '0;
    logic  instrReady;
    logic  issueValid;
    instrT issueInstr;
    logic  issueBubble;

    int    errorCount = 0;
    int    cycle = 0;
    int    seed = 32'h604e_2231;
    int    bubbleCount = 0;
    int    stallDepth = 0;
    logic  stallSeen = 1'b0;
    instrT modelQ[$];
    int    acceptQ[$];
    int    issueCycles[$];
    int    latencies[$];

    issueFrontEnd #(
        .QueueDepth(QueueDepth)
    ) dut (
        .clk        (clk),
        .reset      (reset),
        .instrValid (instrValid),
        .instr      (instr),
        .instrReady (instrReady),
        .issueValid (issueValid),
        .issueInstr (issueInstr),
        .issueBubble(issueBubble)
    );

    always #20 clk = ~clk;

    task automatic reportFailure(input string what);
        errorCount++;
        $display("Error: %s", what);
    endtask

    task automatic checkInstr(input string name, input instrT got, input instrT exp);
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errorCount++;
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic checkCycles(input string name, input int got, input int exp);
        if (got != exp) begin
            errorCount++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    function automatic instrT encode(input opcodeT op, input regIdxT rs, input regIdxT rt,
                                     input immT low);
        return {op, rs, rt, low};
    endfunction

    function automatic instrT aluWord(input regIdxT rs, input regIdxT rt, input regIdxT rd);
        return encode(5'b00000, rs, rt, {rd, 2'b00});
    endfunction

    // sampled mid-cycle, a transfer seen here completes on the next rising edge
    always @(negedge clk) begin
        cycle++;
        if (reset) begin
            modelQ.delete();
            acceptQ.delete();
        end else begin
            if (issueValid && modelQ.size() == 0) begin
                reportFailure("issueValid was high with no word outstanding");
            end else if (issueValid) begin
                checkInstr("issueInstr", issueInstr, modelQ.pop_front());
                issueCycles.push_back(cycle);
                latencies.push_back(cycle - acceptQ.pop_front());
            end
            if (issueBubble) begin
                bubbleCount++;
            end
            if (instrValid && !instrReady && !stallSeen) begin
                stallSeen  = 1'b1;
                stallDepth = modelQ.size();
            end
            if (instrValid && instrReady) begin
                modelQ.push_back(instr);
                acceptQ.push_back(cycle);
            end
        end
    end

    task automatic nextCycle;
        @(posedge clk);
        #2;
    endtask

    task automatic clearLogs;
        issueCycles.delete();
        latencies.delete();
        bubbleCount = 0;
        stallSeen   = 1'b0;
    endtask

    // the source holds its word until the DUT takes it
    task automatic sendWord(input instrT word);
        int   waited;
        logic accepted;
        waited     = 0;
        accepted   = 1'b0;
        instrValid = 1'b1;
        instr      = word;
        while (!accepted && waited < WaitLimit) begin
            @(negedge clk);
            accepted = instrReady;
            nextCycle();
            waited++;
        end
        instrValid = 1'b0;
        if (!accepted) begin
            reportFailure($sformatf("instrReady never rose for word 0x%h", word));
        end
    endtask

    task automatic drain;
        int waited;
        waited = 0;
        while (modelQ.size() != 0 && waited < WaitLimit) begin
            nextCycle();
            waited++;
        end
        if (modelQ.size() != 0) begin
            reportFailure("sent words did not all issue before the timeout");
        end
        // let the last issue leave the shadow
        repeat (ShadowDepth + 1) nextCycle();
    endtask

    task automatic sendPair(input string name, input instrT first, input instrT second,
                            input int spacing);
        clearLogs();
        sendWord(first);
        sendWord(second);
        drain();
        checkCycles({name, " issue count"}, issueCycles.size(), 2);
        if (issueCycles.size() == 2) begin
            checkCycles({name, " latency"}, latencies[0], FillLatency);
            checkCycles({name, " spacing"}, issueCycles[1] - issueCycles[0], spacing);
        end
        // every cycle between the two issues is a held head
        checkCycles({name, " issueBubble cycles"}, bubbleCount, spacing - 1);
    endtask

    task automatic checkStream(input string name, input int count);
        checkCycles({name, " issue count"}, issueCycles.size(), count);
        foreach (latencies[i]) begin
            checkCycles({name, " latency"}, latencies[i], FillLatency);
        end
        checkCycles({name, " issueBubble cycles"}, bubbleCount, 0);
    endtask

    task automatic testReset;
        checkBit("instrReady", instrReady, 1'b1);
        checkBit("issueValid", issueValid, 1'b0);
        checkBit("issueBubble", issueBubble, 1'b0);
        // leave a dependent chain queued, then reset over it
        for (int k = 0; k < 3; k++) begin
            sendWord(aluWord(regIdxT'(k), regIdxT'(k), regIdxT'(k + 1)));
        end
        // a one-cycle reset ends while the write of r1 would still sit in the shadow
        reset = 1'b1;
        nextCycle();
        reset = 1'b0;
        clearLogs();
        // this word reads r1 and would wait on a shadow that survived reset
        sendWord(aluWord(3'd1, 3'd2, 3'd6));
        drain();
        checkStream("after reset", 1);
    endtask

    task automatic testOrder;
        clearLogs();
        for (int k = 0; k < 6; k++) begin
            sendWord(aluWord(3'd0, 3'd1, regIdxT'(k + 2)));
        end
        drain();
        checkStream("independent", 6);
    endtask

    task automatic testRegHazard;
        sendPair("alu Rs dep", aluWord(1, 2, 3), aluWord(3, 0, 4), DepSpacing);
        sendPair("alu Rt dep", aluWord(1, 2, 3), aluWord(0, 3, 4), DepSpacing);
        sendPair("load Rs dep", encode(5'b10000, 1, 5, 7), aluWord(5, 0, 6), DepSpacing);
        sendPair("load Rt dep", encode(5'b10000, 1, 5, 7), aluWord(0, 5, 6), DepSpacing);
    endtask

    task automatic testMemHazard;
        sendPair("store load same", encode(5'b10100, 2, 3, 9), encode(5'b10000, 2, 4, 9),
                 DepSpacing);
        sendPair("store load other", encode(5'b10100, 2, 3, 9), encode(5'b10000, 2, 4, 10), 1);
    endtask

    task automatic testControl;
        sendPair("branch", encode(5'b01100, 1, 0, 0), aluWord(0, 1, 2), CtrlSpacing);
        sendPair("jump", encode(5'b11100, 0, 0, 0), aluWord(0, 1, 2), CtrlSpacing);
        sendPair("idle", encode(5'b11000, 0, 0, 0), aluWord(0, 1, 2), 1);
    endtask

    task automatic testCredits;
        int      r;
        regIdxT  rs;
        regIdxT  rt;
        regIdxT  rd;
        instrT   word;
        clearLogs();
        // each word reads what the one before it writes
        for (int k = 0; k < 10; k++) begin
            sendWord(aluWord(regIdxT'(k), regIdxT'(k), regIdxT'(k + 1)));
        end
        drain();
        checkBit("instrReady low seen", stallSeen, 1'b1);
        checkCycles("words outstanding at stall", stallDepth, QueueDepth);
        checkCycles("chain issue count", issueCycles.size(), 10);
        for (int k = 1; k < issueCycles.size(); k++) begin
            checkCycles("chain spacing", issueCycles[k] - issueCycles[k-1], DepSpacing);
        end
        // reads stay in r0 and r1, writes in r4 to r7, and no loads
        clearLogs();
        for (int k = 0; k < 20; k++) begin
            r  = $random(seed);
            rs = regIdxT'(r[0]);
            rt = regIdxT'(r[1]);
            rd = {1'b1, r[3:2]};
            case (r[5:4])
                2'd0: word = aluWord(rs, rt, rd);
                2'd1: word = encode({3'b010, r[7:6]}, rs, rd, r[12:8]);
                2'd2: word = encode({3'b101, r[7:6]}, rs, rt, r[12:8]);
                default: word = encode({3'b110, r[7:6]}, r[15:13], r[18:16], r[12:8]);
            endcase
            sendWord(word);
            if (r[20]) begin
                nextCycle();
            end
        end
        drain();
        checkStream("random", 20);
    endtask

    initial begin
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        testReset();
        testOrder();
        testRegHazard();
        testMemHazard();
        testControl();
        testCredits();
        $display("Finished with %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- hdl/issueFrontEnd.sv
`timescale 1ns/10ps

module issueFrontEnd #(
    parameter int QueueDepth = pipePkg::DefaultQueueDepth
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          instrValid,
    input  isaPkg::instrT instr,
    output logic          instrReady,
    output logic          issueValid,
    output isaPkg::instrT issueInstr,
    output logic          issueBubble
);
    import isaPkg::*;

    // predecoder to queue
    logic    pushValid;
    instrT   pushInstr;
    opClassE pushClass;
    regIdxT  pushRs;
    regIdxT  pushRt;
    regIdxT  pushRd;
    logic    pushReadsRs;
    logic    pushReadsRt;
    logic    pushWritesRd;
    immT     pushImm;
    logic    creditReturn;

    // queue head to issue stage
    logic    headValid;
    instrT   headInstr;
    opClassE headClass;
    regIdxT  headRs;
    regIdxT  headRt;
    regIdxT  headRd;
    logic    headReadsRs;
    logic    headReadsRt;
    logic    headWritesRd;
    immT     headImm;
    logic    pop;

    instrPredecode #(
        .QueueDepth(QueueDepth)
    ) predecode (
        .clk         (clk),
        .reset       (reset),
        .instrValid  (instrValid),
        .instr       (instr),
        .instrReady  (instrReady),
        .creditReturn(creditReturn),
        .pushValid   (pushValid),
        .pushInstr   (pushInstr),
        .pushClass   (pushClass),
        .pushRs      (pushRs),
        .pushRt      (pushRt),
        .pushRd      (pushRd),
        .pushReadsRs (pushReadsRs),
        .pushReadsRt (pushReadsRt),
        .pushWritesRd(pushWritesRd),
        .pushImm     (pushImm)
    );

    instrQueue #(
        .QueueDepth(QueueDepth)
    ) queue (
        .clk         (clk),
        .reset       (reset),
        .pushValid   (pushValid),
        .pushInstr   (pushInstr),
        .pushClass   (pushClass),
        .pushRs      (pushRs),
        .pushRt      (pushRt),
        .pushRd      (pushRd),
        .pushReadsRs (pushReadsRs),
        .pushReadsRt (pushReadsRt),
        .pushWritesRd(pushWritesRd),
        .pushImm     (pushImm),
        .pop         (pop),
        .headValid   (headValid),
        .headInstr   (headInstr),
        .headClass   (headClass),
        .headRs      (headRs),
        .headRt      (headRt),
        .headRd      (headRd),
        .headReadsRs (headReadsRs),
        .headReadsRt (headReadsRt),
        .headWritesRd(headWritesRd),
        .headImm     (headImm),
        .creditReturn(creditReturn)
    );

    hazardIssue issue (
        .clk         (clk),
        .reset       (reset),
        .headValid   (headValid),
        .headInstr   (headInstr),
        .headClass   (headClass),
        .headRs      (headRs),
        .headRt      (headRt),
        .headRd      (headRd),
        .headReadsRs (headReadsRs),
        .headReadsRt (headReadsRt),
        .headWritesRd(headWritesRd),
        .headImm     (headImm),
        .pop         (pop),
        .issueValid  (issueValid),
        .issueInstr  (issueInstr),
        .issueBubble (issueBubble)
    );

endmodule

//--- hdl/hazardIssue.sv
`timescale 1ns/10ps

module hazardIssue (
    input  logic            clk,
    input  logic            reset,
    input  logic            headValid,
    input  isaPkg::instrT   headInstr,
    input  isaPkg::opClassE headClass,
    input  isaPkg::regIdxT  headRs,
    input  isaPkg::regIdxT  headRt,
    input  isaPkg::regIdxT  headRd,
    input  logic            headReadsRs,
    input  logic            headReadsRt,
    input  logic            headWritesRd,
    input  isaPkg::immT     headImm,
    output logic            pop,
    output logic            issueValid,
    output isaPkg::instrT   issueInstr,
    output logic            issueBubble
);
    import isaPkg::*;
    import pipePkg::*;

    // slot 0 follows the instruction now in ID, the last slot the one in WB
    logic   slotWrites [ShadowDepth];
    regIdxT slotRd     [ShadowDepth];
    logic   slotStore  [ShadowDepth];
    regIdxT slotRs     [ShadowDepth];
    immT    slotImm    [ShadowDepth];

    logic ctrlBubble;
    logic regHazard;
    logic memHazard;
    logic hold;

    always_comb begin
        regHazard = 1'b0;
        memHazard = 1'b0;
        for (int i = 0; i < ShadowDepth; i++) begin
            if (slotWrites[i]) begin
                if (headReadsRs && (slotRd[i] == headRs)) begin
                    regHazard = 1'b1;
                end
                if (headReadsRt && (slotRd[i] == headRt)) begin
                    regHazard = 1'b1;
                end
            end
            // without the Rs value the best guess at an address is base plus offset
            if (slotStore[i] && isLoad(headClass)) begin
                if ((slotRs[i] == headRs) && (slotImm[i] == headImm)) begin
                    memHazard = 1'b1;
                end
            end
        end
    end

    assign hold = regHazard || memHazard || ctrlBubble;
    assign pop  = headValid && !hold;

    // a held or empty cycle shifts an empty slot into the shadow
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < ShadowDepth; i++) begin
                slotWrites[i] <= 1'b0;
                slotStore[i]  <= 1'b0;
            end
        end else begin
            slotWrites[0] <= pop && headWritesRd;
            slotStore[0]  <= pop && isStore(headClass);
            for (int i = 1; i < ShadowDepth; i++) begin
                slotWrites[i] <= slotWrites[i-1];
                slotStore[i]  <= slotStore[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        slotRd[0]  <= headRd;
        slotRs[0]  <= headRs;
        slotImm[0] <= headImm;
        for (int i = 1; i < ShadowDepth; i++) begin
            slotRd[i]  <= slotRd[i-1];
            slotRs[i]  <= slotRs[i-1];
            slotImm[i] <= slotImm[i-1];
        end
    end

    // ctrlBubble lasts exactly one cycle since nothing issues while it is set
    always_ff @(posedge clk) begin
        if (reset) begin
            ctrlBubble  <= 1'b0;
            issueValid  <= 1'b0;
            issueBubble <= 1'b0;
        end else begin
            ctrlBubble  <= pop && isControl(headClass);
            issueValid  <= pop;
            issueBubble <= headValid && hold;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issueInstr <= headInstr;
        end
    end

endmodule

//--- hdl/instrQueue.sv
`timescale 1ns/10ps

module instrQueue #(
    parameter int QueueDepth = pipePkg::DefaultQueueDepth
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            pushValid,
    input  isaPkg::instrT   pushInstr,
    input  isaPkg::opClassE pushClass,
    input  isaPkg::regIdxT  pushRs,
    input  isaPkg::regIdxT  pushRt,
    input  isaPkg::regIdxT  pushRd,
    input  logic            pushReadsRs,
    input  logic            pushReadsRt,
    input  logic            pushWritesRd,
    input  isaPkg::immT     pushImm,
    input  logic            pop,
    output logic            headValid,
    output isaPkg::instrT   headInstr,
    output isaPkg::opClassE headClass,
    output isaPkg::regIdxT  headRs,
    output isaPkg::regIdxT  headRt,
    output isaPkg::regIdxT  headRd,
    output logic            headReadsRs,
    output logic            headReadsRt,
    output logic            headWritesRd,
    output isaPkg::immT     headImm,
    output logic            creditReturn
);
    import isaPkg::*;

    typedef logic [$clog2(QueueDepth)-1:0]     ptrT;
    typedef logic [$clog2(QueueDepth + 1)-1:0] countT;

    instrT   memInstr    [QueueDepth];
    opClassE memClass    [QueueDepth];
    regIdxT  memRs       [QueueDepth];
    regIdxT  memRt       [QueueDepth];
    regIdxT  memRd       [QueueDepth];
    logic    memReadsRs  [QueueDepth];
    logic    memReadsRt  [QueueDepth];
    logic    memWritesRd [QueueDepth];
    immT     memImm      [QueueDepth];

    ptrT   wrPtr;
    ptrT   rdPtr;
    countT count;

    // pointers wrap by compare so the depth need not be a power of two
    function automatic ptrT nextPtr(input ptrT ptr);
        return (ptr == ptrT'(QueueDepth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // the predecoder only pushes with a credit in hand, so a push always fits
    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (pushValid) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            count <= count + countT'(pushValid) - countT'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (pushValid) begin
            memInstr[wrPtr]    <= pushInstr;
            memClass[wrPtr]    <= pushClass;
            memRs[wrPtr]       <= pushRs;
            memRt[wrPtr]       <= pushRt;
            memRd[wrPtr]       <= pushRd;
            memReadsRs[wrPtr]  <= pushReadsRs;
            memReadsRt[wrPtr]  <= pushReadsRt;
            memWritesRd[wrPtr] <= pushWritesRd;
            memImm[wrPtr]      <= pushImm;
        end
    end

    assign headValid    = count != '0;
    assign headInstr    = memInstr[rdPtr];
    assign headClass    = memClass[rdPtr];
    assign headRs       = memRs[rdPtr];
    assign headRt       = memRt[rdPtr];
    assign headRd       = memRd[rdPtr];
    assign headReadsRs  = memReadsRs[rdPtr];
    assign headReadsRt  = memReadsRt[rdPtr];
    assign headWritesRd = memWritesRd[rdPtr];
    assign headImm      = memImm[rdPtr];

    // every freed entry goes straight back to the producer as a credit
    assign creditReturn = pop;

endmodule

//--- hdl/instrPredecode.sv
`timescale 1ns/10ps

module instrPredecode #(
    parameter int QueueDepth = pipePkg::DefaultQueueDepth
) (
    input  logic            clk,
    input  logic            reset,
    input  logic            instrValid,
    input  isaPkg::instrT   instr,
    output logic            instrReady,
    input  logic            creditReturn,
    output logic            pushValid,
    output isaPkg::instrT   pushInstr,
    output isaPkg::opClassE pushClass,
    output isaPkg::regIdxT  pushRs,
    output isaPkg::regIdxT  pushRt,
    output isaPkg::regIdxT  pushRd,
    output logic            pushReadsRs,
    output logic            pushReadsRt,
    output logic            pushWritesRd,
    output isaPkg::immT     pushImm
);
    import isaPkg::*;

    typedef logic [$clog2(QueueDepth + 1)-1:0] creditT;

    creditT  credits;
    logic    accept;
    opcodeT  opcode;
    opClassE decClass;
    logic    decReadsRs;
    logic    decReadsRt;
    logic    decWritesRd;
    regIdxT  decRd;

    // a credit coming back this cycle can be spent right away
    assign instrReady = (credits != '0) || creditReturn;
    assign accept     = instrValid && instrReady;

    assign opcode = instr[OpcodeLsb +: $bits(opcodeT)];

    always_comb begin
        casez (opcode)
            5'b00???: decClass = opAlu;
            5'b010??: decClass = opAluImm;
            5'b011??: decClass = opBranch;
            5'b100??: decClass = opLoad;
            5'b101??: decClass = opStore;
            5'b110??: decClass = opIdle;
            default:  decClass = opJump;
        endcase
    end

    // operand usage per class, Rd position depends on the format
    always_comb begin
        decReadsRs  = 1'b0;
        decReadsRt  = 1'b0;
        decWritesRd = 1'b0;
        decRd       = instr[RdImmLsb +: $bits(regIdxT)];
        case (decClass)
            opAlu: begin
                decReadsRs  = 1'b1;
                decReadsRt  = 1'b1;
                decWritesRd = 1'b1;
                decRd       = instr[RdAluLsb +: $bits(regIdxT)];
            end
            opAluImm, opLoad: begin
                decReadsRs  = 1'b1;
                decWritesRd = 1'b1;
            end
            opBranch: begin
                decReadsRs = 1'b1;
            end
            opStore: begin
                decReadsRs = 1'b1;
                decReadsRt = 1'b1;
            end
            default: begin
                decWritesRd = 1'b0;
            end
        endcase
    end

    // one credit leaves with every accepted word and one returns per pop
    always_ff @(posedge clk) begin
        if (reset) begin
            credits   <= creditT'(QueueDepth);
            pushValid <= 1'b0;
        end else begin
            credits   <= credits - creditT'(accept) + creditT'(creditReturn);
            pushValid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            pushInstr    <= instr;
            pushClass    <= decClass;
            pushRs       <= instr[RsLsb +: $bits(regIdxT)];
            pushRt       <= instr[RtLsb +: $bits(regIdxT)];
            pushRd       <= decRd;
            pushReadsRs  <= decReadsRs;
            pushReadsRt  <= decReadsRt;
            pushWritesRd <= decWritesRd;
            pushImm      <= instr[ImmLsb +: $bits(immT)];
        end
    end

endmodule

//--- hdl/pipePkg.sv
package pipePkg;

    // number of stages behind issue (ID, EX, MEM, WB) whose writes are still
    // pending, so a dependent instruction waits until its producer leaves WB
    localparam int ShadowDepth = 4;

    // entries between predecode and issue when the top level does not choose
    localparam int DefaultQueueDepth = 4;

endpackage

//--- hdl/isaPkg.sv
package isaPkg;

    // one instruction word as fetched
    localparam int InstrWidth = 16;

    typedef logic [InstrWidth-1:0] instrT;
    typedef logic [4:0]            opcodeT;
    typedef logic [2:0]            regIdxT;
    typedef logic [4:0]            immT;

    // operation classes, one per opcode group of the top three opcode bits
    typedef enum logic [2:0] {
        opAlu,
        opAluImm,
        opBranch,
        opLoad,
        opStore,
        opJump,
        opIdle
    } opClassE;

    // lowest bit of each field inside the instruction word
    localparam int OpcodeLsb = 11;
    localparam int RsLsb     = 8;
    localparam int RtLsb     = 5;
    localparam int ImmLsb    = 0;

    // register-register format puts Rd low, the immediate formats reuse the Rt slot
    localparam int RdAluLsb  = 2;
    localparam int RdImmLsb  = 5;

    // branches and jumps both cost one bubble behind them
    function automatic logic isControl(input opClassE opClass);
        return (opClass == opBranch) || (opClass == opJump);
    endfunction

    // a store is tracked by its base register and offset until it leaves WB
    function automatic logic isStore(input opClassE opClass);
        return opClass == opStore;
    endfunction

    function automatic logic isLoad(input opClassE opClass);
        return opClass == opLoad;
    endfunction

endpackage
